// File: controlUnitCases.txt
// columns: reset, opcode, flags {zero negative carry}, memReady, controls expected next cycle
// the first value is the number of case lines
2f
1 0 0 0 1C0000000
1 0 0 0 1C0000000
1 0 0 0 1C0000000
1 0 0 0 1C0000000
1 0 0 0 1C0000000
0 0 0 0 1C0000000
0 0 0 1 000285829
0 0 0 1 001018600
0 0 0 1 1C0000000
0 1 0 1 000285829
0 1 0 1 003018600
0 1 0 1 1C0000000
0 2 0 1 000285829
0 2 0 0 040002040
0 2 0 0 040002040
0 2 0 1 001010002
0 2 0 1 1C0000000
0 3 0 1 000285829
0 3 0 1 020000040
0 3 0 1 000000000
0 3 0 1 1C0000000
0 4 0 1 000285829
0 4 0 1 000000000
0 4 0 1 1C0000000
0 5 0 1 000285829
0 5 0 1 000000001
0 5 0 1 000000181
0 5 0 1 1C0000000
0 6 1 1 000285829
0 6 1 1 000000001
0 6 1 1 1C0000000
0 6 4 1 000285829
0 6 4 1 000000001
0 6 4 1 000000001
0 6 4 1 1C0000000
0 7 0 1 000285829
0 7 0 1 000000001
0 7 0 1 000000181
0 7 0 1 1C0000000
0 b 0 1 000285829
0 b 0 1 1C0000000
0 2 0 1 000285829
0 2 0 0 040002040
1 2 0 0 1C0000000
0 8 0 1 000285829
0 8 0 1 000000181
0 8 0 1 1C0000000

// File: controlUnit.f
controlPkg.sv
microstore.sv
microsequencer.sv
controlUnit.sv
controlUnit_chk.sv
controlUnit_tb.sv

// File: runSim.sh
#!/bin/sh
# build and run the control unit testbench, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module controlUnit_tb -f controlUnit.f -o simControlUnit \
    && ./obj_dir/simControlUnit +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation exited with an error"
grep -qs "^Test passed$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: controlUnit_tb.sv
`timescale 1ns/10ps

module controlUnit_tb;

    localparam int clockPeriod = 8;
    // room for the count word and five words per cycle
    localparam int maxWords    = 512;
    // extra cycles the watchdog allows past the last case
    localparam int slackCycles = 20;

    logic                         clk;
    logic                         reset;
    controlPkg::opcode_t          opcode;
    controlPkg::statusFlags_t     flags;
    logic                         memReady;
    controlPkg::datapathControl_t controls;

    // word 0 is the line count, then reset, opcode, flags, memReady, controls per line
    logic [35:0] caseMem [maxWords];
    int          caseCount;
    bit          casesLoaded;
    int          errorCount;
    int          assertFails;

    controlUnit uut (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .flags    (flags),
        .memReady (memReady),
        .controls (controls)
    );

    always #(clockPeriod / 2) clk = ~clk;

    // controls against the value the cases file expects
    task automatic compareControls(input controlPkg::datapathControl_t expected,
                                   input int caseLine);
        if (controls !== expected) begin
            errorCount++;
            $display("** Error at %0t: controls = %h, expected %h (case line %0d)",
                     $time, controls, expected, caseLine);
        end
    endtask

    // put one line's inputs on the DUT pins
    task automatic applyCase(input int caseLine);
        int base;
        base     = 1 + 5 * caseLine;
        reset    = caseMem[base][0];
        opcode   = caseMem[base + 1][3:0];
        flags    = caseMem[base + 2][2:0];
        memReady = caseMem[base + 3][0];
    endtask

    task automatic runCases();
        for (int i = 0; i < caseCount; i++) begin
            @(posedge clk);
            #1;
            // state moved on this edge, so controls belong to the previous line
            if (i > 0) begin
                compareControls(caseMem[5 * i][32:0], i - 1);
            end
            applyCase(i);
        end
        @(posedge clk);
        #1;
        compareControls(caseMem[5 * caseCount][32:0], caseCount - 1);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        opcode     = '0;
        flags      = '0;
        memReady   = 1'b0;
        errorCount = 0;
        $readmemh("controlUnitCases.txt", caseMem);
        caseCount   = int'(caseMem[0][15:0]);
        casesLoaded = 1'b1;
        if (caseCount < 1 || 1 + 5 * caseCount > maxWords) begin
            $display("cases file holds an unusable line count of %0d", caseCount);
            errorCount++;
        end else begin
            runCases();
        end
        // failures counted inside the bound checker
        assertFails = uut.seqUnit.seqCheck.failCount;
        $display("%0d control mismatches, %0d assertion failures", errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog, sized from the number of case lines
    initial begin
        wait (casesLoaded);
        #((caseCount + slackCycles) * clockPeriod);
        $display("simulation timed out after %0d cycles", caseCount + slackCycles);
        $display("Test failed");
        $finish;
    end

endmodule

// File: controlUnit_chk.sv
`timescale 1ns/10ps

module controlUnit_chk (
    input logic                    clk,
    input logic                    reset,
    input logic                    memReady,
    input controlPkg::opcode_t     latchedOpcode,
    input controlPkg::microWord_t  word,
    input controlPkg::microState_t state
);

    // highest opcode with its own dispatch entry
    localparam controlPkg::opcode_t lastOpcode = 4'd8;

    int failCount = 0;

    // nothing past the end of the microstore table
    stateInRange: assert property (@(posedge clk) disable iff (reset)
        state <= controlPkg::lastState)
        else begin
            $error("microstate %0d is past the table", state);
            failCount++;
        end

    afterReset: assert property (@(posedge clk)
        reset |=> state == controlPkg::fetchState)
        else begin
            $error("microstate %0d after reset, fetch expected", state);
            failCount++;
        end

    // undefined opcodes dispatch back to fetch
    undefinedDispatch: assert property (@(posedge clk) disable iff (reset)
        (word.seqOp == controlPkg::seqDispatch && latchedOpcode > lastOpcode)
        |=> state == controlPkg::fetchState)
        else begin
            $error("dispatch on opcode %0d missed fetch", latchedOpcode);
            failCount++;
        end

    // memory wait holds the state
    memWaitHold: assert property (@(posedge clk) disable iff (reset)
        (word.seqOp == controlPkg::seqBranch && word.condSel == controlPkg::condMemWait
         && !memReady) |=> state == $past(state))
        else begin
            $error("microstate moved to %0d during a memory wait", state);
            failCount++;
        end

endmodule

bind microsequencer controlUnit_chk seqCheck (
    .clk           (clk),
    .reset         (reset),
    .memReady      (memReady),
    .latchedOpcode (latchedOpcode),
    .word          (word),
    .state         (state)
);

// File: controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  logic                         clk,
    input  logic                         reset,
    // opcode field from the instruction bus
    input  controlPkg::opcode_t          opcode,
    input  controlPkg::statusFlags_t     flags,
    // memory ready, a level
    input  logic                         memReady,
    output controlPkg::datapathControl_t controls
);

    // current microstate and its microword
    controlPkg::microState_t state;
    controlPkg::microWord_t  word;

    // state register, opcode latch, next-state choice
    microsequencer seqUnit (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .flags    (flags),
        .memReady (memReady),
        .word     (word),
        .state    (state)
    );

    // combinational lookup, word follows state in the same cycle
    microstore storeUnit (
        .state (state),
        .word  (word)
    );

    // only the datapath half leaves the unit
    assign controls = word.ctrl;

endmodule

// File: microsequencer.sv
`timescale 1ns/10ps

module microsequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  controlPkg::opcode_t      opcode,
    input  controlPkg::statusFlags_t flags,
    input  logic                     memReady,
    input  controlPkg::microWord_t   word,
    output controlPkg::microState_t  state
);

    // start microstate per opcode, undefined opcodes go back to fetch
    localparam controlPkg::microState_t dispatchTable [16] = '{
        // 0 add
        7'd2,
        // 1 sub
        7'd3,
        // 2 load
        7'd4,
        // 3 store
        7'd6,
        // 4 nop
        7'd7,
        // 5 branch if not negative
        7'd8,
        // 6 branch if no carry and not zero
        7'd10,
        // 7 branch if not zero
        7'd11,
        // 8 jump
        7'd12,
        controlPkg::fetchState,
        controlPkg::fetchState,
        controlPkg::fetchState,
        controlPkg::fetchState,
        controlPkg::fetchState,
        controlPkg::fetchState,
        controlPkg::fetchState
    };

    // opcode of the instruction in flight
    controlPkg::opcode_t     latchedOpcode;
    controlPkg::microState_t dispatchState;
    controlPkg::microState_t incState;
    controlPkg::microState_t nextState;
    logic                    condMet;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= controlPkg::fetchState;
            latchedOpcode <= '0;
        end else begin
            state <= nextState;
            // IR load and opcode capture happen on the same edge
            if (word.ctrl.loadIr) begin
                latchedOpcode <= opcode;
            end
        end
    end

    assign dispatchState = dispatchTable[latchedOpcode];
    assign incState      = controlPkg::microState_t'(state + 7'd1);

    // selected branch condition
    always_comb begin
        condMet = 1'b0;
        case (word.condSel)
            controlPkg::condMemWait: begin
                condMet = !memReady;
            end
            controlPkg::condZero: begin
                condMet = flags.zero;
            end
            controlPkg::condNegative: begin
                condMet = flags.negative;
            end
            controlPkg::condCarry: begin
                condMet = flags.carry;
            end
            default: begin
                condMet = 1'b0;
            end
        endcase
    end

    // next microstate
    always_comb begin
        nextState = controlPkg::fetchState;
        case (word.seqOp)
            controlPkg::seqNext: begin
                nextState = incState;
            end
            controlPkg::seqDispatch: begin
                nextState = dispatchState;
            end
            controlPkg::seqBranch: begin
                // not taken falls through to the following step
                nextState = condMet ? word.jumpTarget : incState;
            end
            controlPkg::seqFetch: begin
                nextState = controlPkg::fetchState;
            end
            default: begin
                nextState = controlPkg::fetchState;
            end
        endcase
    end

endmodule

// File: microstore.sv
`timescale 1ns/10ps

module microstore (
    input  controlPkg::microState_t state,
    output controlPkg::microWord_t  word
);

    // the two halves of the word, built separately
    controlPkg::datapathControl_t ctrl;
    controlPkg::seqOp_t           seqOp;
    controlPkg::condSel_t         condSel;
    controlPkg::microState_t      jumpTarget;

    always_comb begin
        // everything idle, back to fetch, each entry raises only what it needs
        ctrl       = '0;
        seqOp      = controlPkg::seqFetch;
        condSel    = controlPkg::condMemWait;
        jumpTarget = controlPkg::fetchState;
        case (state)
            controlPkg::decodeState: begin
                // read rs and rt, effective address rs + imm straight into MAR
                ctrl.aLoad      = 1'b1;
                ctrl.bLoad      = 1'b1;
                ctrl.regSelA    = controlPkg::fieldRs;
                ctrl.regSelB    = controlPkg::fieldRt;
                ctrl.aluSrcA    = 1'b1;
                ctrl.aluSrcB    = 2'd1;
                ctrl.immEnable  = 1'b1;
                ctrl.aluOp      = controlPkg::aluAdd;
                ctrl.marLoad    = 1'b1;
                seqOp           = controlPkg::seqDispatch;
            end
            7'd2, 7'd3: begin
                // add and sub, A op B written to rd
                ctrl.aluOp      = (state == 7'd2) ? controlPkg::aluAdd : controlPkg::aluSub;
                ctrl.aluOutLoad = 1'b1;
                ctrl.flagsLoad  = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.regSelDest = controlPkg::fieldRd;
            end
            7'd4: begin
                // load read at MAR, hold until ready
                ctrl.memRead    = 1'b1;
                ctrl.memAddrSel = 1'b1;
                ctrl.mdrLoad    = 1'b1;
                seqOp           = controlPkg::seqBranch;
                jumpTarget      = 7'd4;
            end
            7'd5: begin
                // load write back, MDR into rt
                ctrl.regWrite   = 1'b1;
                ctrl.regSelDest = controlPkg::fieldRt;
                ctrl.regDataSel = 2'd1;
            end
            7'd6: begin
                // store B at MAR
                ctrl.memWrite   = 1'b1;
                ctrl.memAddrSel = 1'b1;
                seqOp           = controlPkg::seqBranch;
                jumpTarget      = 7'd6;
            end
            // 7 is the empty step, store completion and nop
            7'd7: ;
            7'd8, 7'd10, 7'd11: begin
                // branch tests skip to fetch when the flag is set
                ctrl.immEnable  = 1'b1;
                seqOp           = controlPkg::seqBranch;
                condSel         = (state == 7'd8)  ? controlPkg::condNegative :
                                  (state == 7'd10) ? controlPkg::condCarry :
                                                     controlPkg::condZero;
            end
            7'd9, 7'd12: begin
                // branch taken, pc gets pc + offset
                ctrl.immEnable  = 1'b1;
                ctrl.pcLoad     = 1'b1;
                ctrl.pcSrcSel   = 1'b1;
            end
            default: begin
                // fetch at state 0, and anything past the table lands here too
                ctrl.loadIr      = 1'b1;
                ctrl.pcIncrement = 1'b1;
                ctrl.memRead     = 1'b1;
                seqOp            = controlPkg::seqBranch;
            end
        endcase
    end

    assign word = '{ctrl: ctrl, seqOp: seqOp, condSel: condSel, jumpTarget: jumpTarget};

endmodule

// File: controlPkg.sv
package controlPkg;

    // microstate number, states 0 to 12 are in use
    typedef logic [6:0] microState_t;
    typedef logic [3:0] opcode_t;
    typedef logic [3:0] aluOp_t;
    // which IR register field the datapath decodes, 0 selects none
    typedef logic [2:0] regSel_t;

    // registered ALU status from the datapath
    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
    } statusFlags_t;

    // how the sequencer picks the next microstate
    typedef enum logic [1:0] {
        seqNext,
        seqDispatch,
        seqBranch,
        seqFetch
    } seqOp_t;

    // branch conditions, memWait is true while memReady is low
    typedef enum logic [1:0] {
        condMemWait,
        condZero,
        condNegative,
        condCarry
    } condSel_t;

    // 33 datapath control bits, loadIr is the msb
    typedef struct packed {
        logic       loadIr;
        logic       pcIncrement;
        logic       memRead;
        logic       memWrite;
        aluOp_t     aluOp;
        logic       regWrite;
        regSel_t    regSelA;
        regSel_t    regSelB;
        regSel_t    regSelDest;
        logic       marLoad;
        logic       mdrLoad;
        logic       aLoad;
        logic       bLoad;
        logic       aluOutLoad;
        logic       flagsLoad;
        logic       pcLoad;
        // 0 takes the incrementer, 1 the pc plus offset adder
        logic       pcSrcSel;
        // 0 addresses memory from pc, 1 from MAR
        logic       memAddrSel;
        // 0 takes the A register, 1 the register file port directly
        logic       aluSrcA;
        // 0 B register, 1 immediate, 2 constant one, 3 register file port
        logic [1:0] aluSrcB;
        // 0 ALU result, 1 MDR, 2 immediate, 3 pc
        logic [1:0] regDataSel;
        logic       immEnable;
    } datapathControl_t;

    // full 44-bit microword, datapath half on top
    typedef struct packed {
        datapathControl_t ctrl;
        seqOp_t           seqOp;
        condSel_t         condSel;
        microState_t      jumpTarget;
    } microWord_t;

    localparam microState_t fetchState  = 7'd0;
    localparam microState_t decodeState = 7'd1;
    localparam microState_t lastState   = 7'd12;

    localparam aluOp_t aluAdd = 4'd0;
    localparam aluOp_t aluSub = 4'd1;

    // IR register fields
    localparam regSel_t fieldRs = 3'd1;
    localparam regSel_t fieldRt = 3'd2;
    localparam regSel_t fieldRd = 3'd3;

endpackage
